//--- common/snake_defines.svh
// Grid size, field widths, start positions and LFSR seeds of the snake game
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// Playing field in cells
`define GRID_WIDTH    124
`define GRID_HEIGHT   81

// Field widths
`define COORD_BITS    7           // Covers 0..127, enough for both axes
`define LENGTH_BITS   4
`define SCORE_BITS    8

// Segment storage derived from the length width
`define MAX_SEGMENTS  (1 << `LENGTH_BITS)
`define BODY_SLOTS    (`MAX_SEGMENTS - 1)   // Head is held apart from the body

// Start of every game
`define START_HEAD_X  8
`define START_HEAD_Y  40
`define START_LENGTH  6           // Head included
`define START_FRUIT_X 8
`define START_FRUIT_Y 42

// Fruit search seeds, must be non-zero
`define SEED_X        7'h1C
`define SEED_Y        7'h30

`endif

//--- common/grid_pkg.sv
// Geometry types: grid coordinate, cell, snake length and score
`include "snake_defines.svh"

package grid_pkg;

    // One axis position on the grid
    typedef logic [`COORD_BITS-1:0] coord_t;

    // A grid cell, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    typedef logic [`LENGTH_BITS-1:0] length_t;  // Segments including the head

    typedef logic [`SCORE_BITS-1:0] score_t;    // Fruits eaten this game

endpackage

//--- common/game_pkg.sv
// Game control types: FSM states, heading and turn command

package game_pkg;

    // Main game FSM
    typedef enum logic [2:0] {
        IDLE,           // Start values loaded, waiting for a button
        WAIT,           // Waiting for the next game tick
        MOVING,         // Next cell checked against walls and body
        MOVE_DONE,      // Move committed
        FRUIT_REQ,      // Fruit placer searching for a free cell
        FRUIT_RELEASE,  // Handshake return to zero
        GAME_OVER       // Final board held
    } game_state_t;

    // Clockwise order, so a turn is plus or minus one
    typedef enum logic [1:0] {
        UP,
        RIGHT,
        DOWN,
        LEFT
    } heading_t;

    typedef enum logic [1:0] {
        TURN_NONE,
        TURN_CW,
        TURN_CCW
    } turn_t;

endpackage

//--- common/snake_ifs.sv
// Interfaces steer_if, move_if and fruit_if with their modports
`timescale 1ns/1ps

// Buttons and heading between decoder and controller
interface steer_if;
    import game_pkg::*;

    logic     press;    // One-cycle pulse on any button edge
    heading_t heading;  // Heading for the next move
    logic     restart;  // High in IDLE
    logic     commit;   // High in MOVE_DONE

    modport decode (output press, output heading, input restart, input commit);
    modport control (input press, output restart, output commit);
endinterface

// Move step between controller and snake body
interface move_if;
    import grid_pkg::*;

    cell_t   next_cell;  // Cell the head would enter
    logic    blocked;    // Next cell is a wall or body
    cell_t   head;
    length_t length;
    logic    commit;     // Shift body and move head
    logic    grow;       // Add one segment
    logic    restart;    // Load start snake

    modport control (input blocked, output commit, output grow, output restart);
    modport body (
        output next_cell,
        output blocked,
        output head,
        output length,
        input  commit,
        input  grow,
        input  restart
    );
    modport monitor (input head, input next_cell);
endinterface

// Fruit handshake plus the cell lookup into the body
interface fruit_if;
    import grid_pkg::*;

    logic  req;       // Four-phase request for a new fruit
    logic  ack;
    logic  eaten;     // Next cell holds the fruit
    logic  restart;   // Load start fruit and clear score
    cell_t probe;     // Candidate fruit cell
    logic  occupied;  // Probe lies on the snake

    modport control (output req, output restart, input ack, input eaten);
    modport placer (
        input  req,
        input  restart,
        input  occupied,
        output ack,
        output eaten,
        output probe
    );
    modport lookup (input probe, output occupied);
endinterface

//--- src/input_decode.sv
// Button edge detectors, pending turn latch and heading register
`timescale 1ns/1ps

module input_decode (
    input  logic               clock_25,
    input  logic               reset,
    input  logic               right_p,
    input  logic               left_p,
    steer_if.decode            steer,
    output game_pkg::heading_t heading
);
    import game_pkg::*;

    logic [1:0] right_shift;   // Button history, bit 0 newest
    logic [1:0] left_shift;
    logic       right_edge;
    logic       left_edge;
    turn_t      turn_pending;  // Turn waiting for the next move
    heading_t   heading_reg;   // Heading of the last committed move
    heading_t   heading_next;  // Heading with the pending turn applied

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_shift <= 2'b00;
            left_shift  <= 2'b00;
        end else begin
            right_shift <= {right_shift[0], right_p};
            left_shift  <= {left_shift[0], left_p};
        end
    end

    assign right_edge  = right_shift[0] & ~right_shift[1];  // Rising edges only
    assign left_edge   = left_shift[0] & ~left_shift[1];
    assign steer.press = right_edge | left_edge;

    // Last press wins until the move uses it
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_pending <= TURN_NONE;
        end else if (steer.restart) begin
            turn_pending <= TURN_NONE;       // Starting press never turns
        end else if (right_edge && left_edge) begin
            turn_pending <= TURN_NONE;       // Both at once keep the heading
        end else if (right_edge) begin
            turn_pending <= TURN_CW;
        end else if (left_edge) begin
            turn_pending <= TURN_CCW;
        end else if (steer.commit) begin
            turn_pending <= TURN_NONE;       // Consumed by this move
        end
    end

    always_comb begin
        case (turn_pending)
            TURN_CW:  heading_next = heading_t'(heading_reg + 2'd1);
            TURN_CCW: heading_next = heading_t'(heading_reg - 2'd1);
            default:  heading_next = heading_reg;
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            heading_reg <= RIGHT;
        end else if (steer.restart) begin
            heading_reg <= RIGHT;            // Every game starts to the right
        end else if (steer.commit) begin
            heading_reg <= heading_next;
        end
    end

    // Pending turn already shows, so the tick after a press uses it
    assign heading       = heading_next;
    assign steer.heading = heading_next;

endmodule

//--- control/game_control.sv
// Game FSM sequencing tick moves, fruit handshake and game over
`timescale 1ns/1ps

module game_control (
    input  logic     clock_25,
    input  logic     reset,
    input  logic     game_tik,
    output logic     game_over,
    steer_if.control steer,
    move_if.control  move,
    fruit_if.control fruit
);
    import game_pkg::*;

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;                   // Hold by default
        case (state)
            IDLE: begin
                if (steer.press) state_next = WAIT;
            end
            WAIT: begin
                if (game_tik) state_next = MOVING;  // Ticks count only here
            end
            MOVING: begin
                // Check comes before the move, head stays put on a hit
                if (move.blocked) begin
                    state_next = GAME_OVER;
                end else begin
                    state_next = MOVE_DONE;
                end
            end
            MOVE_DONE: begin
                if (fruit.eaten) begin
                    state_next = FRUIT_REQ;
                end else begin
                    state_next = WAIT;
                end
            end
            FRUIT_REQ: begin
                if (fruit.ack) state_next = FRUIT_RELEASE;
            end
            FRUIT_RELEASE: begin
                if (!fruit.ack) state_next = WAIT;  // Placer back to idle
            end
            GAME_OVER: begin
                if (steer.press) state_next = IDLE;  // Board kept until then
            end
            default: state_next = IDLE;
        endcase
    end

    // Moore outputs, grow is the one-cycle exception on ack
    assign steer.restart = (state == IDLE);
    assign steer.commit  = (state == MOVE_DONE);
    assign move.restart  = (state == IDLE);
    assign move.commit   = (state == MOVE_DONE);
    assign move.grow     = (state == FRUIT_REQ) && fruit.ack;
    assign fruit.restart = (state == IDLE);
    assign fruit.req     = (state == FRUIT_REQ);
    assign game_over     = (state == GAME_OVER);

endmodule

//--- snake_body/snake_body.sv
// Head and body registers, next-cell step, wall and self collision, occupancy lookup
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_body (
    input  logic               clock_25,
    input  logic               reset,
    input  game_pkg::heading_t heading,
    move_if.body               move,
    fruit_if.lookup            lookup
);
    import game_pkg::*;
    import grid_pkg::*;

    cell_t   head;
    cell_t   body [`BODY_SLOTS];  // Slot 0 sits right behind the head
    length_t length;
    length_t seg_count;          // Body segments in use
    cell_t   step;               // Cell ahead along the heading
    logic    wall_hit;
    logic    body_hit;
    logic    probe_hit;

    always_comb begin
        step     = head;
        wall_hit = 1'b0;
        case (heading)
            UP: begin
                wall_hit = (head.y == '0);
                step.y   = head.y - 1'b1;
            end
            DOWN: begin
                wall_hit = (head.y == coord_t'(`GRID_HEIGHT - 1));
                step.y   = head.y + 1'b1;
            end
            LEFT: begin
                wall_hit = (head.x == '0);
                step.x   = head.x - 1'b1;
            end
            default: begin               // RIGHT
                wall_hit = (head.x == coord_t'(`GRID_WIDTH - 1));
                step.x   = head.x + 1'b1;
            end
        endcase
    end

    assign seg_count = length - 1'b1;

    always_comb begin
        body_hit = 1'b0;
        for (int i = 0; i < `BODY_SLOTS; i++) begin
            if ((length_t'(i) < seg_count) && (body[i] == step)) body_hit = 1'b1;
        end
    end

    // One slot past the tail counts too, after a commit it holds the
    // old tail that grow is about to claim
    always_comb begin
        probe_hit = (lookup.probe == head);
        for (int i = 0; i < `BODY_SLOTS; i++) begin
            if ((length_t'(i) < length) && (body[i] == lookup.probe)) probe_hit = 1'b1;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head.x <= coord_t'(`START_HEAD_X);
            head.y <= coord_t'(`START_HEAD_Y);
            length <= length_t'(`START_LENGTH);
        end else if (move.restart) begin
            head.x <= coord_t'(`START_HEAD_X);
            head.y <= coord_t'(`START_HEAD_Y);
            length <= length_t'(`START_LENGTH);
        end else begin
            if (move.commit) head <= step;
            if (move.grow && (length != '1)) length <= length + 1'b1;  // Saturates
        end
    end

    // Whole chain shifts, so the slot past the tail keeps the old tail
    always_ff @(posedge clock_25) begin
        if (move.restart) begin
            for (int i = 0; i < `BODY_SLOTS; i++) begin
                if (i < `START_LENGTH - 1) begin
                    body[i].x <= coord_t'(`START_HEAD_X - 1 - i);  // Trailing left
                    body[i].y <= coord_t'(`START_HEAD_Y);
                end else begin
                    body[i] <= '1;                                  // Off the grid
                end
            end
        end else if (move.commit) begin
            body[0] <= head;
            for (int i = 1; i < `BODY_SLOTS; i++) begin
                body[i] <= body[i-1];
            end
        end
    end

    assign move.head        = head;
    assign move.length      = length;
    assign move.next_cell   = step;
    assign move.blocked     = wall_hit | body_hit;
    assign lookup.occupied  = probe_hit;

endmodule

//--- fruit/fruit_placer.sv
// Fruit register, eaten detection, LFSR search for a free cell and score counter
`timescale 1ns/1ps
`include "snake_defines.svh"

module fruit_placer (
    input  logic             clock_25,
    input  logic             reset,
    move_if.monitor          snake,
    fruit_if.placer          fruit,
    output grid_pkg::coord_t fruit_x,
    output grid_pkg::coord_t fruit_y,
    output grid_pkg::score_t score
);
    import grid_pkg::*;

    coord_t lfsr_x;      // x^7+x^6+1, period 127
    coord_t lfsr_y;
    cell_t  fruit_cell;
    score_t score_reg;
    logic   ack_reg;
    logic   in_grid;
    logic   probe_free;
    logic   accept;      // Probe becomes the new fruit

    // Free-running, so the search start depends on when the fruit was eaten
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr_x <= `SEED_X;
            lfsr_y <= `SEED_Y;
        end else begin
            lfsr_x <= {lfsr_x[5:0], lfsr_x[6] ^ lfsr_x[5]};
            lfsr_y <= {lfsr_y[5:0], lfsr_y[6] ^ lfsr_y[5]};
        end
    end

    assign fruit.probe = '{x: lfsr_x, y: lfsr_y};

    // LFSR range is 1..127, wider than the grid on both axes
    assign in_grid    = (lfsr_x < coord_t'(`GRID_WIDTH)) &&
                        (lfsr_y < coord_t'(`GRID_HEIGHT));
    assign probe_free = !fruit.occupied && (fruit.probe != snake.head);
    assign accept     = fruit.req && !ack_reg && in_grid && probe_free;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit_cell.x <= coord_t'(`START_FRUIT_X);
            fruit_cell.y <= coord_t'(`START_FRUIT_Y);
            score_reg    <= '0;
        end else if (fruit.restart) begin
            fruit_cell.x <= coord_t'(`START_FRUIT_X);
            fruit_cell.y <= coord_t'(`START_FRUIT_Y);
            score_reg    <= '0;
        end else if (accept) begin
            fruit_cell <= fruit.probe;
            score_reg  <= score_reg + 1'b1;  // One point per fruit
        end
    end

    // Ack rises with the stored fruit, falls once req has dropped
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            ack_reg <= 1'b0;
        end else if (accept) begin
            ack_reg <= 1'b1;
        end else if (!fruit.req) begin
            ack_reg <= 1'b0;
        end
    end

    assign fruit.ack   = ack_reg;
    assign fruit.eaten = (snake.next_cell == fruit_cell);  // Looked at before the move
    assign fruit_x     = fruit_cell.x;
    assign fruit_y     = fruit_cell.y;
    assign score       = score_reg;

endmodule

//--- src/snake_game_top.sv
// Snake game engine top: decoder, controller, body and fruit placer
`timescale 1ns/1ps

module snake_game_top (
    input  logic              clock_25,
    input  logic              reset,
    input  logic              game_tik,
    input  logic              right_p,
    input  logic              left_p,
    output grid_pkg::coord_t  head_x,
    output grid_pkg::coord_t  head_y,
    output grid_pkg::coord_t  fruit_x,
    output grid_pkg::coord_t  fruit_y,
    output grid_pkg::length_t snake_length,
    output grid_pkg::score_t  score,
    output logic              game_over
);
    import game_pkg::*;

    heading_t heading;         // Decoder straight to the body

    steer_if steer_bus ();
    move_if  move_bus ();
    fruit_if fruit_bus ();

    input_decode u_decode (
        .clock_25 (clock_25),
        .reset    (reset),
        .right_p  (right_p),
        .left_p   (left_p),
        .steer    (steer_bus.decode),
        .heading  (heading)
    );

    game_control u_control (
        .clock_25  (clock_25),
        .reset     (reset),
        .game_tik  (game_tik),
        .game_over (game_over),
        .steer     (steer_bus.control),
        .move      (move_bus.control),
        .fruit     (fruit_bus.control)
    );

    snake_body u_body (
        .clock_25 (clock_25),
        .reset    (reset),
        .heading  (heading),
        .move     (move_bus.body),
        .lookup   (fruit_bus.lookup)
    );

    fruit_placer u_fruit (
        .clock_25 (clock_25),
        .reset    (reset),
        .snake    (move_bus.monitor),
        .fruit    (fruit_bus.placer),
        .fruit_x  (fruit_x),
        .fruit_y  (fruit_y),
        .score    (score)
    );

    // Head and length taken from the body side of the move bus
    assign head_x       = move_bus.head.x;
    assign head_y       = move_bus.head.y;
    assign snake_length = move_bus.length;

endmodule

//--- testbench/snake_tb.sv
// Snake game testbench with action table, move model, typed compare tasks and watchdog
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_tb;
    import grid_pkg::*;
    import game_pkg::*;

    typedef enum logic [1:0] {ACT_TICK, ACT_RIGHT, ACT_LEFT, ACT_BOTH} action_t;
    typedef enum logic [1:0] {PH_IDLE, PH_PLAY, PH_OVER} phase_t;

    // One action and the board expected after it
    typedef struct {
        action_t action;
        int      x;
        int      y;
        int      len;
        int      pts;
        logic    over;
    } row_t;

    logic    clock_25;
    logic    reset;
    logic    game_tik;
    logic    right_p;
    logic    left_p;
    coord_t  head_x;
    coord_t  head_y;
    coord_t  fruit_x;
    coord_t  fruit_y;
    length_t snake_length;
    score_t  score;
    logic    game_over;

    row_t     steps [$];     // Stimulus table
    logic     table_ready;

    // Model of the game as seen from the buttons
    phase_t   m_phase;
    heading_t m_heading;
    turn_t    m_turn;        // Turn waiting for the next tick
    cell_t    m_head;
    cell_t    m_body [$];    // Front sits right behind the head
    cell_t    m_fruit;
    int       m_length;      // Head included
    logic     fruit_moved;   // Fruit eaten and new place not yet read back

    snake_game_top dut (
        .clock_25     (clock_25),
        .reset        (reset),
        .game_tik     (game_tik),
        .right_p      (right_p),
        .left_p       (left_p),
        .head_x       (head_x),
        .head_y       (head_y),
        .fruit_x      (fruit_x),
        .fruit_y      (fruit_y),
        .snake_length (snake_length),
        .score        (score),
        .game_over    (game_over)
    );

    always #5 clock_25 = ~clock_25;  // 10 ns period

    function automatic cell_t make_cell(coord_t x, coord_t y);
        cell_t c;
        c.x = x;
        c.y = y;
        return c;
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_cell(string what, cell_t got, cell_t want);
        if (got !== want) begin
            $display("FAIL %s: got x=%h y=%h, expected x=%h y=%h",
                     what, got.x, got.y, want.x, want.y);
            abort_run();
        end
    endtask

    task automatic check_length(string what, length_t got, length_t want);
        if (got !== want) begin
            $display("FAIL %s: got %h, expected %h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_score(string what, score_t got, score_t want);
        if (got !== want) begin
            $display("FAIL %s: got %h, expected %h", what, got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(string what, logic got, logic want);
        if (got !== want) begin
            $display("FAIL %s: got %h, expected %h", what, got, want);
            abort_run();
        end
    endtask

    // Clockwise order UP, RIGHT, DOWN, LEFT
    function automatic heading_t turned(heading_t h, turn_t t);
        heading_t cw;
        heading_t ccw;
        case (h)
            UP:      cw = RIGHT;
            RIGHT:   cw = DOWN;
            DOWN:    cw = LEFT;
            default: cw = UP;
        endcase
        case (h)
            UP:      ccw = LEFT;
            LEFT:    ccw = DOWN;
            DOWN:    ccw = RIGHT;
            default: ccw = UP;
        endcase
        case (t)
            TURN_CW:  return cw;
            TURN_CCW: return ccw;
            default:  return h;
        endcase
    endfunction

    function automatic logic on_body(cell_t c);
        logic hit;
        hit = 1'b0;
        foreach (m_body[i]) begin
            if (m_body[i] == c) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic load_start_board();
        m_phase     = PH_IDLE;
        m_heading   = RIGHT;
        m_turn      = TURN_NONE;
        m_head      = make_cell(coord_t'(`START_HEAD_X), coord_t'(`START_HEAD_Y));
        m_fruit     = make_cell(coord_t'(`START_FRUIT_X), coord_t'(`START_FRUIT_Y));
        m_length    = `START_LENGTH;
        fruit_moved = 1'b0;
        m_body.delete();
        for (int i = 1; i < `START_LENGTH; i++) begin
            m_body.push_back(make_cell(coord_t'(`START_HEAD_X - i), coord_t'(`START_HEAD_Y)));
        end
    endtask

    task automatic apply_press(logic r, logic l);
        case (m_phase)
            PH_IDLE: begin
                m_phase = PH_PLAY;
                m_turn  = TURN_NONE;          // Starting press never turns
            end
            PH_OVER: load_start_board();      // Back to the start board
            default: begin
                if (r && l) m_turn = TURN_NONE;
                else if (r) m_turn = TURN_CW;
                else m_turn = TURN_CCW;       // Last press wins
            end
        endcase
    endtask

    task automatic advance_model();
        heading_t h;
        cell_t    nc;
        int       nx;
        int       ny;
        if (m_phase == PH_PLAY) begin
            h  = turned(m_heading, m_turn);
            nx = int'(m_head.x);
            ny = int'(m_head.y);
            case (h)
                UP:      ny = ny - 1;
                DOWN:    ny = ny + 1;
                LEFT:    nx = nx - 1;
                default: nx = nx + 1;
            endcase
            nc = make_cell(coord_t'(nx), coord_t'(ny));
            if (nx < 0 || nx >= `GRID_WIDTH || ny < 0 || ny >= `GRID_HEIGHT ||
                on_body(nc)) begin
                m_phase = PH_OVER;            // Head stays where it was
            end else begin
                if (nc == m_fruit) begin
                    m_length    = m_length + 1;
                    fruit_moved = 1'b1;
                end
                m_body.push_front(m_head);
                m_head    = nc;
                m_heading = h;
                m_turn    = TURN_NONE;
                while (m_body.size() > m_length - 1) void'(m_body.pop_back());
            end
        end
    endtask

    // New fruit has to be on the grid and off the snake
    task automatic accept_new_fruit();
        cell_t f;
        f = make_cell(fruit_x, fruit_y);
        if (f.x >= coord_t'(`GRID_WIDTH) || f.y >= coord_t'(`GRID_HEIGHT)) begin
            $display("New fruit at x=%h y=%h lies outside the grid", f.x, f.y);
            abort_run();
        end
        if (f == m_head || on_body(f)) begin
            $display("New fruit at x=%h y=%h lies on the snake", f.x, f.y);
            abort_run();
        end
        m_fruit     = f;
        fruit_moved = 1'b0;
    endtask

    task automatic press_buttons(logic r, logic l);
        @(negedge clock_25);
        right_p = r;
        left_p  = l;
        apply_press(r, l);
        @(negedge clock_25);
        right_p = 1'b0;
        left_p  = 1'b0;
        repeat (10) @(negedge clock_25);  // Edge detect and FSM settle
    endtask

    task automatic send_tick();
        cell_t head_before;
        head_before = m_head;
        @(negedge clock_25);
        game_tik = 1'b1;
        advance_model();
        @(negedge clock_25);              // Edge E has sampled the tick
        game_tik = 1'b0;
        @(negedge clock_25);              // After E+1
        check_flag("game_over", game_over, m_phase == PH_OVER);
        check_cell("head at E+1", make_cell(head_x, head_y), head_before);
        @(negedge clock_25);              // After E+2
        check_cell("head at E+2", make_cell(head_x, head_y), m_head);
        repeat (157) @(negedge clock_25); // Rest of the 160-cycle spacing covers the fruit search
        if (fruit_moved) accept_new_fruit();
    endtask

    task automatic add_row(action_t a, int x, int y, int len, int pts, logic over);
        row_t r;
        r.action = a;
        r.x      = x;
        r.y      = y;
        r.len    = len;
        r.pts    = pts;
        r.over   = over;
        steps.push_back(r);
    endtask

    task automatic fill_table();
        add_row(ACT_TICK,  8, 40, 6, 0, 0);   // Ignored before the start press
        add_row(ACT_RIGHT, 8, 40, 6, 0, 0);   // Start press keeps RIGHT
        add_row(ACT_TICK,  9, 40, 6, 0, 0);
        add_row(ACT_TICK, 10, 40, 6, 0, 0);
        add_row(ACT_LEFT, 10, 40, 6, 0, 0);   // Now UP
        add_row(ACT_TICK, 10, 39, 6, 0, 0);
        add_row(ACT_BOTH, 10, 39, 6, 0, 0);   // Both buttons keep UP
        add_row(ACT_TICK, 10, 38, 6, 0, 0);
        add_row(ACT_RIGHT, 10, 38, 6, 0, 0);  // Back to RIGHT
        add_row(ACT_TICK, 11, 38, 6, 0, 0);
        add_row(ACT_TICK, 12, 38, 6, 0, 0);
        // Three clockwise turns curl the head into its own body
        add_row(ACT_RIGHT, 12, 38, 6, 0, 0);
        add_row(ACT_TICK,  12, 39, 6, 0, 0);
        add_row(ACT_RIGHT, 12, 39, 6, 0, 0);
        add_row(ACT_TICK,  11, 39, 6, 0, 0);
        add_row(ACT_RIGHT, 11, 39, 6, 0, 0);
        add_row(ACT_TICK,  11, 39, 6, 0, 1);
        add_row(ACT_RIGHT, 8, 40, 6, 0, 0);   // Restart loads the start board
        add_row(ACT_LEFT,  8, 40, 6, 0, 0);   // New game without a turn
        // Straight to the last column and then into the wall
        for (int x = 9; x < `GRID_WIDTH; x++) begin
            add_row(ACT_TICK, x, 40, 6, 0, 0);
        end
        add_row(ACT_TICK,  `GRID_WIDTH - 1, 40, 6, 0, 1);
        add_row(ACT_RIGHT, 8, 40, 6, 0, 0);
        add_row(ACT_RIGHT, 8, 40, 6, 0, 0);
        // Loop round onto the start fruit
        add_row(ACT_TICK,  9, 40, 6, 0, 0);
        add_row(ACT_RIGHT, 9, 40, 6, 0, 0);
        add_row(ACT_TICK,  9, 41, 6, 0, 0);
        add_row(ACT_TICK,  9, 42, 6, 0, 0);
        add_row(ACT_RIGHT, 9, 42, 6, 0, 0);
        add_row(ACT_TICK,  8, 42, 7, 1, 0);
        // Grown snake with a point curls into its body before the restart
        add_row(ACT_RIGHT, 8, 42, 7, 1, 0);
        add_row(ACT_TICK,  8, 41, 7, 1, 0);
        add_row(ACT_RIGHT, 8, 41, 7, 1, 0);
        add_row(ACT_TICK,  8, 41, 7, 1, 1);
        add_row(ACT_RIGHT, 8, 40, 6, 0, 0);   // Score, length and fruit back to start
    endtask

    // Watchdog sized from the table
    initial begin
        wait (table_ready);
        repeat (steps.size() * 200) @(posedge clock_25);
        $display("Watchdog expired after %0d cycles, table not finished", steps.size() * 200);
        abort_run();
    end

    initial begin
        row_t  r;
        cell_t want;
        clock_25    = 1'b0;
        reset       = 1'b0;
        game_tik    = 1'b0;
        right_p     = 1'b0;
        left_p      = 1'b0;
        table_ready = 1'b0;
        fill_table();
        table_ready = 1'b1;
        load_start_board();
        repeat (5) @(posedge clock_25);   // Five cycles in reset
        @(negedge clock_25);
        reset = 1'b1;
        repeat (2) @(negedge clock_25);
        check_cell("head", make_cell(head_x, head_y), m_head);
        check_length("snake_length", snake_length, length_t'(`START_LENGTH));
        check_score("score", score, score_t'(0));
        check_cell("fruit", make_cell(fruit_x, fruit_y), m_fruit);
        check_flag("game_over", game_over, 1'b0);
        foreach (steps[i]) begin
            r = steps[i];
            case (r.action)
                ACT_TICK:  send_tick();
                ACT_RIGHT: press_buttons(1'b1, 1'b0);
                ACT_LEFT:  press_buttons(1'b0, 1'b1);
                default:   press_buttons(1'b1, 1'b1);
            endcase
            want = make_cell(coord_t'(r.x), coord_t'(r.y));
            check_cell("head", make_cell(head_x, head_y), want);
            check_length("snake_length", snake_length, length_t'(r.len));
            check_score("score", score, score_t'(r.pts));
            check_flag("game_over", game_over, r.over);
            check_cell("fruit", make_cell(fruit_x, fruit_y), m_fruit);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- snake_game.f
+incdir+common
common/grid_pkg.sv
common/game_pkg.sv
common/snake_ifs.sv
src/input_decode.sv
control/game_control.sv
snake_body/snake_body.sv
fruit/fruit_placer.sv
src/snake_game_top.sv
testbench/snake_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module snake_tb -f snake_game.f -o snake_sim
	./obj_dir/snake_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean
